// ==== src/lockstep_pkg.sv ====
////////////////////////////////////////////////////////////////////////////
// Payloads are packed structs, so the checker can compare them as a whole
// with a single inequality.
////////////////////////////////////////////////////////////////////////////

package lockstep_pkg;

  // Width of the operand and the accumulator
  localparam int unsigned DataW = 16;

  ////////////////////////////////////////////////////////////////////////////
  // Operation encoding
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic [1:0] {
    OpLoad = 2'b00,
    OpAdd  = 2'b01,
    OpXor  = 2'b10,
    OpClr  = 2'b11
  } acc_op_e;

  ////////////////////////////////////////////////////////////////////////////
  // Core payloads
  ////////////////////////////////////////////////////////////////////////////

  // Inputs to the core, 19 bits
  typedef struct packed {
    logic             in_valid;
    acc_op_e          op;
    logic [DataW-1:0] operand;
  } core_in_t;

  // Outputs of the core, 17 bits
  typedef struct packed {
    logic             res_valid;
    logic [DataW-1:0] acc;
  } core_out_t;

endpackage

// ==== src/shadow_rst_seq.sv ====
////////////////////////////////////////////////////////////////////////////
// LockstepOffset must be at least 1. The shadow reset leaves reset
// synchronously; the compare enable follows one cycle later.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module shadow_rst_seq #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  output logic rst_shadow_no,
  output logic cmp_en_o
);

  // A single bit still covers an offset of 1
  localparam int unsigned CntW = (LockstepOffset > 1) ? $clog2(LockstepOffset) : 1;

  logic [CntW-1:0] cnt_d, cnt_q;
  logic            set_d, set_q;
  logic            en_q;

  // Counter stops once the offset is reached
  assign set_d = (cnt_q == CntW'(LockstepOffset - 1));
  assign cnt_d = set_d ? cnt_q : cnt_q + 1'b1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cnt_q <= '0;
      set_q <= 1'b0;
      en_q  <= 1'b0;
    end else begin
      cnt_q <= cnt_d;
      set_q <= set_q | set_d;
      en_q  <= set_q;
    end
  end

  assign rst_shadow_no = set_q;
  assign cmp_en_o      = en_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Comparing against a shadow core held in reset would flag false faults
  a_en_after_shadow_rst : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    cmp_en_o |-> rst_shadow_no
  ) else $error("Compare enabled while shadow core is in reset");

endmodule

// ==== src/lockstep_delay.sv ====
////////////////////////////////////////////////////////////////////////////
// Output is the input from Depth cycles before. All entries clear to zero
// on reset, so the output reads zero for Depth cycles afterwards.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lockstep_delay #(
  parameter type         T     = logic,
  parameter int unsigned Depth = 1
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  T     data_i,
  output T     data_o
);

  if (Depth < 1) begin : g_depth_check
    $error("lockstep_delay needs a Depth of at least 1");
  end

  // Entry 0 is the oldest
  T stage_q [Depth];

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int unsigned i = 0; i < Depth; i++) begin
        stage_q[i] <= T'('0);
      end
    end else begin
      for (int unsigned i = 0; i + 1 < Depth; i++) begin
        stage_q[i] <= stage_q[i+1];
      end
      stage_q[Depth-1] <= data_i;
    end
  end

  assign data_o = stage_q[0];

endmodule

// ==== src/acc_core.sv ====
////////////////////////////////////////////////////////////////////////////
// Single accumulator, one operation per valid input. The result and its
// strobe appear the cycle after the input; addition wraps.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module acc_core (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  lockstep_pkg::core_in_t  in_i,
  output lockstep_pkg::core_out_t out_o
);

  logic [lockstep_pkg::DataW-1:0] acc_d, acc_q;
  logic                           res_valid_q;

  ////////////////////////////////////////////////////////////////////////////
  // Next accumulator value
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    acc_d = acc_q;
    if (in_i.in_valid) begin
      case (in_i.op)
        lockstep_pkg::OpLoad: begin
          acc_d = in_i.operand;
        end
        lockstep_pkg::OpAdd: begin
          acc_d = acc_q + in_i.operand;
        end
        lockstep_pkg::OpXor: begin
          acc_d = acc_q ^ in_i.operand;
        end
        lockstep_pkg::OpClr: begin
          acc_d = '0;
        end
        default: begin
          acc_d = acc_q;
        end
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // State
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      acc_q       <= '0;
      res_valid_q <= 1'b0;
    end else begin
      acc_q       <= acc_d;
      // Strobe lasts exactly one cycle per valid input
      res_valid_q <= in_i.in_valid;
    end
  end

  assign out_o.res_valid = res_valid_q;
  assign out_o.acc       = acc_q;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // An unknown op would silently hold the accumulator
  a_op_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    in_i.in_valid |-> !$isunknown(in_i.op)
  ) else $error("Unknown op with in_valid high");

endmodule

// ==== src/lockstep_cmp.sv ====
////////////////////////////////////////////////////////////////////////////
// Main outputs must already be delayed by LockstepOffset+1 cycles. The
// alert is combinational and only valid while the enable is high.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lockstep_cmp (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    cmp_en_i,
  input  lockstep_pkg::core_out_t shadow_out_i,
  input  lockstep_pkg::core_out_t main_out_i,
  output logic                    alert_major_o
);

  lockstep_pkg::core_out_t shadow_out_q;
  logic                    mismatch;

  // One extra stage on the shadow side lines it up with the main delay line
  always_ff @(posedge clk_i) begin
    shadow_out_q <= shadow_out_i;
  end

  // Any differing bit counts, strobe or data
  assign mismatch      = (shadow_out_q != main_out_i);
  assign alert_major_o = cmp_en_i & mismatch;

  ////////////////////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////////////////////

  // Shadow side must be fully defined by the time compare starts
  a_alert_known : assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_major_o)
  ) else $error("Major alert is unknown");

endmodule

// ==== src/lockstep_top.sv ====
////////////////////////////////////////////////////////////////////////////
// The shadow core runs LockstepOffset cycles behind the main core; legal
// offsets are 1 to 8. Only output mismatches drive the major alert.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module lockstep_top #(
  parameter int unsigned LockstepOffset = 2
) (
  input  logic                           clk_i,
  input  logic                           rst_ni,
  input  logic                           core_in_valid_i,
  input  lockstep_pkg::acc_op_e          core_op_i,
  input  logic [lockstep_pkg::DataW-1:0] core_operand_i,
  input  logic                           core_res_valid_i,
  input  logic [lockstep_pkg::DataW-1:0] core_acc_i,
  output logic                           alert_major_o
);

  // Main outputs wait one more cycle for the shadow output register
  localparam int unsigned OutputsOffset = LockstepOffset + 1;

  lockstep_pkg::core_in_t  core_in;
  lockstep_pkg::core_in_t  shadow_in;
  lockstep_pkg::core_out_t core_out;
  lockstep_pkg::core_out_t core_out_dly;
  lockstep_pkg::core_out_t shadow_out;
  logic                    rst_shadow_n;
  logic                    cmp_en;

  ////////////////////////////////////////////////////////////////////////////
  // Reset sequencing
  ////////////////////////////////////////////////////////////////////////////

  shadow_rst_seq #(
    .LockstepOffset(LockstepOffset)
  ) u_rst_seq (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rst_shadow_no(rst_shadow_n),
    .cmp_en_o     (cmp_en)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Input delay and shadow core
  ////////////////////////////////////////////////////////////////////////////

  assign core_in.in_valid = core_in_valid_i;
  assign core_in.op       = core_op_i;
  assign core_in.operand  = core_operand_i;

  lockstep_delay #(
    .T    (lockstep_pkg::core_in_t),
    .Depth(LockstepOffset)
  ) u_in_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(core_in),
    .data_o(shadow_in)
  );

  acc_core u_shadow_core (
    .clk_i (clk_i),
    .rst_ni(rst_shadow_n),
    .in_i  (shadow_in),
    .out_o (shadow_out)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Output delay and compare
  ////////////////////////////////////////////////////////////////////////////

  assign core_out.res_valid = core_res_valid_i;
  assign core_out.acc       = core_acc_i;

  lockstep_delay #(
    .T    (lockstep_pkg::core_out_t),
    .Depth(OutputsOffset)
  ) u_out_delay (
    .clk_i (clk_i),
    .rst_ni(rst_ni),
    .data_i(core_out),
    .data_o(core_out_dly)
  );

  lockstep_cmp u_cmp (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .cmp_en_i     (cmp_en),
    .shadow_out_i (shadow_out),
    .main_out_i   (core_out_dly),
    .alert_major_o(alert_major_o)
  );

endmodule

// ==== verification/tb_lockstep.sv ====
////////////////////////////////////////////////////////////////////////////
// Pattern rows are written for LockstepOffset 2; each expected alert flag
// already sits 3 rows after the faulty main output that causes it.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ns

module tb_lockstep;

  localparam int unsigned LockstepOffset = 2;
  localparam int unsigned ClkPeriod      = 10;
  localparam int unsigned ResetCycles    = 4;
  localparam string       PatternFile    = "verification/lockstep_patterns.txt";

  // One replayed cycle, or a reset request when is_reset is set
  typedef struct packed {
    logic                           is_reset;
    logic [15:0]                    line_no;
    logic                           in_valid;
    logic [1:0]                     op;
    logic [lockstep_pkg::DataW-1:0] operand;
    logic                           res_valid;
    logic [lockstep_pkg::DataW-1:0] acc;
    logic                           alert;
  } row_t;

  logic                           clk_i;
  logic                           rst_ni;
  logic                           core_in_valid_i;
  lockstep_pkg::acc_op_e          core_op_i;
  logic [lockstep_pkg::DataW-1:0] core_operand_i;
  logic                           core_res_valid_i;
  logic [lockstep_pkg::DataW-1:0] core_acc_i;
  logic                           alert_major_o;

  row_t   rows[$];
  bit     rows_loaded;
  integer seed;

  lockstep_top #(
    .LockstepOffset(LockstepOffset)
  ) u_lockstep_top (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .core_in_valid_i (core_in_valid_i),
    .core_op_i       (core_op_i),
    .core_operand_i  (core_operand_i),
    .core_res_valid_i(core_res_valid_i),
    .core_acc_i      (core_acc_i),
    .alert_major_o   (alert_major_o)
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #(ClkPeriod / 2) clk_i = ~clk_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Errors found");
    $fatal(1, "Simulation stopped");
  endtask

  task automatic load_patterns();
    int          fd;
    int          line_cnt;
    int          n;
    string       line;
    row_t        row;
    logic [31:0] f_valid, f_op, f_operand, f_rvalid, f_acc, f_alert;
    line_cnt = 0;
    fd = $fopen(PatternFile, "r");
    if (fd == 0) begin
      abort_run({"Could not open the pattern file ", PatternFile});
    end
    while ($fgets(line, fd) > 0) begin
      line_cnt++;
      if (line.len() < 2 || line.getc(0) == "#") begin
        continue;
      end
      row         = '0;
      row.line_no = line_cnt[15:0];
      if (line.substr(0, 2) == "rst") begin
        row.is_reset = 1'b1;
      end else begin
        n = $sscanf(line, "%h %h %h %h %h %h",
                    f_valid, f_op, f_operand, f_rvalid, f_acc, f_alert);
        if (n != 6) begin
          abort_run($sformatf("Pattern file line %0d is malformed", line_cnt));
        end
        row.in_valid  = f_valid[0];
        row.op        = f_op[1:0];
        row.operand   = f_operand[lockstep_pkg::DataW-1:0];
        row.res_valid = f_rvalid[0];
        row.acc       = f_acc[lockstep_pkg::DataW-1:0];
        row.alert     = f_alert[0];
      end
      rows.push_back(row);
    end
    $fclose(fd);
  endtask

  // Sample mid-cycle, where the alert is settled
  task automatic check_alert(input logic expected, input string what);
    @(negedge clk_i);
    a_alert_match : assert (alert_major_o === expected) else begin
      abort_run($sformatf("ERR %0t ns: %s expected alert %0b, got %0b",
                          $time, what, expected, alert_major_o));
    end
  endtask

  task automatic apply_reset();
    logic [31:0] rnd_in;
    logic [31:0] rnd_out;
    for (int i = 0; i < ResetCycles; i++) begin
      rnd_in  = $random(seed);
      rnd_out = $random(seed);
      @(posedge clk_i);
      rst_ni           <= 1'b0;
      core_in_valid_i  <= rnd_in[16];
      core_op_i        <= lockstep_pkg::acc_op_e'(rnd_in[18:17]);
      core_operand_i   <= rnd_in[lockstep_pkg::DataW-1:0];
      // Nonzero main outputs while in reset
      core_res_valid_i <= 1'b1;
      core_acc_i       <= {rnd_out[lockstep_pkg::DataW-1:1], 1'b1};
      check_alert(1'b0, $sformatf("reset cycle %0d", i));
    end
  endtask

  task automatic drive_row(input row_t row);
    logic [31:0] rnd;
    rnd = $random(seed);
    @(posedge clk_i);
    rst_ni           <= 1'b1;
    core_in_valid_i  <= row.in_valid;
    core_op_i        <= lockstep_pkg::acc_op_e'(row.op);
    // Idle cycles carry a random operand that the core must ignore
    core_operand_i   <= row.in_valid ? row.operand : rnd[lockstep_pkg::DataW-1:0];
    core_res_valid_i <= row.res_valid;
    core_acc_i       <= row.acc;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    seed             = 32'h1f5c_c6de;
    rst_ni           = 1'b0;
    core_in_valid_i  = 1'b0;
    core_op_i        = lockstep_pkg::OpLoad;
    core_operand_i   = '0;
    core_res_valid_i = 1'b0;
    core_acc_i       = '0;
    load_patterns();
    rows_loaded = 1'b1;
    apply_reset();
    foreach (rows[i]) begin
      if (rows[i].is_reset) begin
        apply_reset();
      end else begin
        drive_row(rows[i]);
        check_alert(rows[i].alert, $sformatf("pattern line %0d", rows[i].line_no));
      end
    end
    $display("No errors");
    $finish;
  end

  // Limit follows the number of replayed cycles
  initial begin
    longint unsigned cycles;
    wait (rows_loaded);
    cycles = ResetCycles;
    foreach (rows[i]) begin
      cycles += rows[i].is_reset ? ResetCycles : 1;
    end
    #((cycles + 20) * ClkPeriod);
    abort_run("Timeout: the pattern replay did not finish in time");
  end

endmodule

// ==== verification/lockstep_patterns.txt ====
# Columns (hex): in_valid op operand main_res_valid main_acc expected_alert
# A line holding only rst applies a four-cycle reset; text after # is ignored
1 0 1234 0 0000 0
1 1 0101 1 1234 0
1 2 00ff 1 1335 0
0 0 0000 1 13ca 0
1 1 f000 0 13ca 0
1 3 0000 1 03ca 0
1 0 beef 1 0000 0
1 1 4111 1 beef 0
1 2 5a5a 1 0000 0
0 0 0000 1 5a5a 0
0 0 0000 0 5a5a 0
1 2 ffff 0 5a5a 0
1 1 0001 1 a5a5 0
1 0 0042 1 a5ae 0  # bit 3 of acc flipped
1 1 0010 1 0042 0
1 1 0010 1 0052 0
0 0 0000 1 0062 1
0 0 0000 0 0062 0
1 2 0f0f 0 0062 0
0 0 0000 0 0f6d 0  # missing strobe
0 0 0000 0 0f6d 0
1 1 1000 1 0f6d 0  # extra strobe
1 3 0000 1 1f6d 1
0 0 0000 1 0000 0
1 0 c001 0 0000 1
1 1 0003 1 4001 0  # bit 15 of acc flipped
1 2 00f0 0 c004 0  # missing strobe
1 1 0100 1 c0f5 0  # bit 0 of acc flipped
0 0 0000 1 c1f4 1
0 0 0000 0 c1f4 1
1 0 7777 0 c1f4 1
1 2 1111 1 7777 0
1 1 0002 1 6666 0
0 0 0000 1 6668 0
0 0 0000 0 6e68 0  # alert would land in the reset below
1 0 abcd 0 6668 0
1 1 0001 1 abcd 0
rst
1 0 0a0a 0 0000 0
1 1 0a0a 1 0a0a 0
0 0 0000 1 1414 0
1 2 ffff 0 1414 0
1 3 0000 1 ebeb 0
0 0 0000 1 0100 0  # bit 8 of acc flipped
0 0 0000 0 0000 0
1 0 1357 0 0000 0
0 0 0000 1 1357 1
0 0 0000 0 1357 0
0 0 0000 0 1357 0
0 0 0000 0 1357 0

// ==== list.f ====
src/lockstep_pkg.sv
src/shadow_rst_seq.sv
src/lockstep_delay.sv
src/acc_core.sv
src/lockstep_cmp.sv
src/lockstep_top.sv
verification/tb_lockstep.sv

// ==== Bender.yml ====
package:
  name: lockstep_checker

sources:
  - src/lockstep_pkg.sv
  - src/shadow_rst_seq.sv
  - src/lockstep_delay.sv
  - src/acc_core.sv
  - src/lockstep_cmp.sv
  - src/lockstep_top.sv
  - target: test
    files:
      - verification/tb_lockstep.sv
